// ==== source/app_pkg.sv ====
// Shared definitions for the application core
// Word, address and strobe typedefs
// Host and local-bus address map
// Timer and version constants, PIO and timer register offsets

package app_pkg;

    // Bus vectors
    typedef logic [31:0] word_t;
    typedef logic [31:0] host_adr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [21:0] lb_adr_t;
    typedef logic [15:0] reg_adr_t;
    typedef logic [9:0]  ram_adr_t;

    // Target index, local-bus address bits 21:16
    typedef logic [5:0]  lb_port_t;

    // Address map
    localparam int       LB_SEL_BIT  = 31;
    localparam lb_port_t LB_PORT_PIO = 6'd0;
    localparam lb_port_t LB_PORT_TMR = 6'd1;
    localparam lb_port_t LB_PORT_EXT = 6'd2;

    // Timing and version
    localparam int SYS_FREQ      = 50_000_000;
    localparam int TMR_BEAT      = SYS_FREQ / 1_000_000;
    localparam int TMR_PRE_WIDTH = $clog2(TMR_BEAT);
    localparam int HW_VER_MAJOR  = 1;
    localparam int HW_VER_MINOR  = 2;

    // PIO registers
    localparam reg_adr_t PIO_REG_VER = 16'd0;
    localparam reg_adr_t PIO_REG_OUT = 16'd1;
    localparam reg_adr_t PIO_REG_SET = 16'd2;
    localparam reg_adr_t PIO_REG_CLR = 16'd3;
    localparam reg_adr_t PIO_REG_IN  = 16'd4;

    // Timer registers
    localparam reg_adr_t TMR_REG_CTL = 16'd0;
    localparam reg_adr_t TMR_REG_CNT = 16'd1;
    localparam reg_adr_t TMR_REG_CMP = 16'd2;
    localparam reg_adr_t TMR_REG_STA = 16'd3;

endpackage

// ==== source/app_data_ram.sv ====
// Data RAM, 1024 words of 32 bits
// Byte-lane write strobes
// Registered read with a one-cycle valid pulse

`timescale 1ns/1ns

module app_data_ram
    import app_pkg::*;
(
    input  logic     CLK_IN,
    input  logic     reset,
    input  ram_adr_t adr,
    input  logic     wr,
    input  logic     rd,
    input  word_t    wr_dat,
    input  strb_t    wr_strb,
    output word_t    rd_dat,
    output logic     rd_vld
);

    // Storage, one entry per word address
    word_t mem [2**$bits(ram_adr_t)];

    // Write, only lanes with a set strobe change
    always_ff @(posedge CLK_IN)
    begin
        if (wr)
        begin
            for (int i = 0; i < $bits(strb_t); i++)
            begin
                if (wr_strb[i])
                    mem[adr][i*8 +: 8] <= wr_dat[i*8 +: 8];
            end
        end
    end

    // Read data held until the next read
    always_ff @(posedge CLK_IN)
    begin
        if (rd)
            rd_dat <= mem[adr];
    end

    // Valid one cycle after the read strobe
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            rd_vld <= 1'b0;
        else
            rd_vld <= rd;
    end

endmodule

// ==== source/app_lb_mux.sv ====
// Local-bus multiplexer
// Target decode on address bits 21:16, strobes routed to PIO, timer or external port
// Read data return and zero response for unmapped targets

`timescale 1ns/1ns

module app_lb_mux
    import app_pkg::*;
(
    input  logic     CLK_IN,
    input  logic     reset,
    // Upstream
    input  lb_adr_t  up_adr,
    input  logic     up_wr,
    input  logic     up_rd,
    input  word_t    up_din,
    output word_t    up_dout,
    output logic     up_vld,
    // PIO target
    output reg_adr_t pio_adr,
    output logic     pio_wr,
    output logic     pio_rd,
    output word_t    pio_din,
    input  word_t    pio_dout,
    input  logic     pio_vld,
    // Timer target
    output reg_adr_t tmr_adr,
    output logic     tmr_wr,
    output logic     tmr_rd,
    output word_t    tmr_din,
    input  word_t    tmr_dout,
    input  logic     tmr_vld,
    // External target
    output reg_adr_t ext_adr,
    output logic     ext_wr,
    output logic     ext_rd,
    output word_t    ext_din,
    input  word_t    ext_dout,
    input  logic     ext_vld
);

    lb_port_t port_idx;
    logic     sel_pio;
    logic     sel_tmr;
    logic     sel_ext;
    logic     unmapped_vld;

    // Target index above the 16-bit register address
    assign port_idx = up_adr[$bits(reg_adr_t) +: $bits(lb_port_t)];
    assign sel_pio  = (port_idx == LB_PORT_PIO);
    assign sel_tmr  = (port_idx == LB_PORT_TMR);
    assign sel_ext  = (port_idx == LB_PORT_EXT);

    // Address and data fan out to all, strobes go to the selected one only
    assign pio_adr = up_adr[0 +: $bits(reg_adr_t)];
    assign tmr_adr = up_adr[0 +: $bits(reg_adr_t)];
    assign ext_adr = up_adr[0 +: $bits(reg_adr_t)];
    assign pio_din = up_din;
    assign tmr_din = up_din;
    assign ext_din = up_din;

    assign pio_wr = up_wr && sel_pio;
    assign pio_rd = up_rd && sel_pio;
    assign tmr_wr = up_wr && sel_tmr;
    assign tmr_rd = up_rd && sel_tmr;
    assign ext_wr = up_wr && sel_ext;
    assign ext_rd = up_rd && sel_ext;

    // Reads to no target still complete a cycle later
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            unmapped_vld <= 1'b0;
        else
            unmapped_vld <= up_rd && !(sel_pio || sel_tmr || sel_ext);
    end

    // Return path, unmapped falls through to zero
    always_comb
    begin
        if (pio_vld)
            up_dout = pio_dout;
        else if (tmr_vld)
            up_dout = tmr_dout;
        else if (ext_vld)
            up_dout = ext_dout;
        else
            up_dout = '0;
    end

    assign up_vld = pio_vld || tmr_vld || ext_vld || unmapped_vld;

endmodule

// ==== source/app_pio.sv ====
// PIO register block
// Version word, output register with set and clear, input sampling
// One-cycle registered reads

`timescale 1ns/1ns

module app_pio
    import app_pkg::*;
(
    input  logic     CLK_IN,
    input  logic     reset,
    input  reg_adr_t adr,
    input  logic     wr,
    input  logic     rd,
    input  word_t    din,
    output word_t    dout,
    output logic     vld,
    input  word_t    pio_in,
    output word_t    pio_out
);

    word_t out_reg;

    // Output register, direct write or bitwise set and clear
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            out_reg <= '0;
        else if (wr)
        begin
            case (adr)
                PIO_REG_OUT : out_reg <= din;
                PIO_REG_SET : out_reg <= out_reg | din;
                PIO_REG_CLR : out_reg <= out_reg & ~din;
                default     : out_reg <= out_reg;
            endcase
        end
    end

    assign pio_out = out_reg;

    // Read data, input pins captured in the read cycle
    always_ff @(posedge CLK_IN)
    begin
        if (rd)
        begin
            case (adr)
                PIO_REG_VER : dout <= {16'(HW_VER_MAJOR), 16'(HW_VER_MINOR)};
                PIO_REG_OUT : dout <= out_reg;
                PIO_REG_IN  : dout <= pio_in;
                default     : dout <= '0;
            endcase
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            vld <= 1'b0;
        else
            vld <= rd;
    end

endmodule

// ==== source/app_timer.sv ====
// Microsecond timer
// Prescaler of TMR_BEAT clocks, run control, count and compare
// Sticky compare interrupt, one-cycle registered reads

`timescale 1ns/1ns

module app_timer
    import app_pkg::*;
(
    input  logic     CLK_IN,
    input  logic     reset,
    input  reg_adr_t adr,
    input  logic     wr,
    input  logic     rd,
    input  word_t    din,
    output word_t    dout,
    output logic     vld,
    output logic     irq
);

    logic                     run;
    logic [TMR_PRE_WIDTH-1:0] pre;
    logic                     tick;
    word_t                    cnt;
    word_t                    cmp;
    logic                     sta;

    // One tick per microsecond while running
    assign tick = run && (pre == TMR_PRE_WIDTH'(TMR_BEAT - 1));

    always_ff @(posedge CLK_IN)
    begin
        if (reset)
        begin
            run <= 1'b0;
            pre <= '0;
            cnt <= '0;
            cmp <= '0;
            sta <= 1'b0;
        end
        else
        begin
            // Prescaler
            if (tick || !run)
                pre <= '0;
            else
                pre <= pre + 1'b1;

            // Count, match checked only on a tick so reset state stays quiet
            if (tick)
                cnt <= cnt + 1'b1;

            // Control write restarts count and prescaler
            if (wr && adr == TMR_REG_CTL)
            begin
                run <= din[0];
                pre <= '0;
                cnt <= '0;
            end
            if (wr && adr == TMR_REG_CNT)
                cnt <= din;
            if (wr && adr == TMR_REG_CMP)
                cmp <= din;

            // Write one to clear, a match in the same cycle wins
            if (wr && adr == TMR_REG_STA && din[0])
                sta <= 1'b0;
            if (tick && (cnt + 1'b1) == cmp)
                sta <= 1'b1;
        end
    end

    assign irq = sta;

    // Register read back
    always_ff @(posedge CLK_IN)
    begin
        if (rd)
        begin
            case (adr)
                TMR_REG_CTL : dout <= {31'd0, run};
                TMR_REG_CNT : dout <= cnt;
                TMR_REG_CMP : dout <= cmp;
                TMR_REG_STA : dout <= {31'd0, sta};
                default     : dout <= '0;
            endcase
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            vld <= 1'b0;
        else
            vld <= rd;
    end

endmodule

// ==== source/app_top.sv ====
// Application core top level
// Registered reset, host access split between data RAM and local bus
// Read data merge and interrupt merge

`timescale 1ns/1ns

module app_top
    import app_pkg::*;
(
    input  logic      CLK_IN,
    input  logic      reset,
    // Host master
    input  host_adr_t host_adr,
    input  logic      host_wr,
    input  logic      host_rd,
    input  word_t     host_wr_dat,
    input  strb_t     host_wr_strb,
    output word_t     host_rd_dat,
    output logic      host_rd_vld,
    // PIO pins
    input  word_t     pio_in,
    output word_t     pio_out,
    // External local-bus port
    output reg_adr_t  ext_adr,
    output logic      ext_wr,
    output logic      ext_rd,
    output word_t     ext_din,
    input  word_t     ext_dout,
    input  logic      ext_vld,
    // Interrupts
    input  logic      ext_irq,
    output logic      irq
);

    logic     reset_q;

    // RAM side
    ram_adr_t ram_adr;
    logic     ram_wr;
    logic     ram_rd;
    word_t    ram_rd_dat;
    logic     ram_rd_vld;

    // Local-bus side
    lb_adr_t  lb_adr;
    logic     lb_wr;
    logic     lb_rd;
    word_t    lb_dout;
    logic     lb_vld;

    // PIO and timer targets
    reg_adr_t pio_adr;
    logic     pio_wr;
    logic     pio_rd;
    word_t    pio_din;
    word_t    pio_dout;
    logic     pio_vld;
    reg_adr_t tmr_adr;
    logic     tmr_wr;
    logic     tmr_rd;
    word_t    tmr_din;
    word_t    tmr_dout;
    logic     tmr_vld;
    logic     tmr_irq;

    // One register stage on reset, shared by all blocks
    always_ff @(posedge CLK_IN)
    begin
        reset_q <= reset;
    end

    // Bit 31 low selects RAM, word address from bits 11:2
    assign ram_adr = host_adr[2 +: $bits(ram_adr_t)];
    assign ram_wr  = host_wr && !host_adr[LB_SEL_BIT];
    assign ram_rd  = host_rd && !host_adr[LB_SEL_BIT];

    // Bit 31 high selects local bus
    assign lb_adr = host_adr[2 +: $bits(lb_adr_t)];
    assign lb_wr  = host_wr && host_adr[LB_SEL_BIT];
    assign lb_rd  = host_rd && host_adr[LB_SEL_BIT];

    // Local bus wins when both report, only one read is ever in flight
    assign host_rd_dat = lb_vld ? lb_dout : ram_rd_dat;
    assign host_rd_vld = lb_vld || ram_rd_vld;

    assign irq = tmr_irq || ext_irq;

    app_data_ram i_data_ram (
        .CLK_IN  (CLK_IN),
        .reset   (reset_q),
        .adr     (ram_adr),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .wr_dat  (host_wr_dat),
        .wr_strb (host_wr_strb),
        .rd_dat  (ram_rd_dat),
        .rd_vld  (ram_rd_vld)
    );

    app_lb_mux i_lb_mux (
        .CLK_IN   (CLK_IN),
        .reset    (reset_q),
        .up_adr   (lb_adr),
        .up_wr    (lb_wr),
        .up_rd    (lb_rd),
        .up_din   (host_wr_dat),
        .up_dout  (lb_dout),
        .up_vld   (lb_vld),
        .pio_adr  (pio_adr),
        .pio_wr   (pio_wr),
        .pio_rd   (pio_rd),
        .pio_din  (pio_din),
        .pio_dout (pio_dout),
        .pio_vld  (pio_vld),
        .tmr_adr  (tmr_adr),
        .tmr_wr   (tmr_wr),
        .tmr_rd   (tmr_rd),
        .tmr_din  (tmr_din),
        .tmr_dout (tmr_dout),
        .tmr_vld  (tmr_vld),
        .ext_adr  (ext_adr),
        .ext_wr   (ext_wr),
        .ext_rd   (ext_rd),
        .ext_din  (ext_din),
        .ext_dout (ext_dout),
        .ext_vld  (ext_vld)
    );

    app_pio i_pio (
        .CLK_IN  (CLK_IN),
        .reset   (reset_q),
        .adr     (pio_adr),
        .wr      (pio_wr),
        .rd      (pio_rd),
        .din     (pio_din),
        .dout    (pio_dout),
        .vld     (pio_vld),
        .pio_in  (pio_in),
        .pio_out (pio_out)
    );

    app_timer i_timer (
        .CLK_IN (CLK_IN),
        .reset  (reset_q),
        .adr    (tmr_adr),
        .wr     (tmr_wr),
        .rd     (tmr_rd),
        .din    (tmr_din),
        .dout   (tmr_dout),
        .vld    (tmr_vld),
        .irq    (tmr_irq)
    );

endmodule

// ==== test/tb_app_top.sv ====
// Directed testbench for the application core
// Clock, reset, host bus tasks and typed compare tasks
// External local-bus target model with random read latency
// Tests for RAM, PIO, external port, unmapped index, timer and interrupt merge
// Watchdog sized from the test lengths

`timescale 1ns/1ns

module tb_app_top
    import app_pkg::*;
;

    // Clock period and test budget in cycles
    localparam int   CLK_NS      = 20;
    localparam int   TEST_CYCLES = 200 + 100 + 200 + 10 * 50 + 8 * 50 + 100;
    localparam int   WATCHDOG_NS = TEST_CYCLES * CLK_NS + 10_000;
    // External target read data key
    localparam word_t EXT_KEY    = 32'h5A00_C3C3;

    logic      CLK_IN;
    logic      reset;
    host_adr_t host_adr;
    logic      host_wr;
    logic      host_rd;
    word_t     host_wr_dat;
    strb_t     host_wr_strb;
    word_t     host_rd_dat;
    logic      host_rd_vld;
    word_t     pio_in;
    word_t     pio_out;
    reg_adr_t  ext_adr;
    logic      ext_wr;
    logic      ext_rd;
    word_t     ext_din;
    word_t     ext_dout;
    logic      ext_vld;
    logic      ext_irq;
    logic      irq;

    int        errors;
    int        seed;

    // External target model state
    int        ext_wr_cnt;
    int        ext_rd_cnt;
    reg_adr_t  ext_wr_adr_log[$];
    word_t     ext_wr_dat_log[$];
    logic      rd_pending;
    int        rd_wait;
    reg_adr_t  rd_adr;

    app_top i_app_top (
        .CLK_IN       (CLK_IN),
        .reset        (reset),
        .host_adr     (host_adr),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_wr_dat  (host_wr_dat),
        .host_wr_strb (host_wr_strb),
        .host_rd_dat  (host_rd_dat),
        .host_rd_vld  (host_rd_vld),
        .pio_in       (pio_in),
        .pio_out      (pio_out),
        .ext_adr      (ext_adr),
        .ext_wr       (ext_wr),
        .ext_rd       (ext_rd),
        .ext_din      (ext_din),
        .ext_dout     (ext_dout),
        .ext_vld      (ext_vld),
        .ext_irq      (ext_irq),
        .irq          (irq)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever #(CLK_NS / 2) CLK_IN = ~CLK_IN;
    end

    // External target with random read latency of 1 to 8 cycles
    always @(posedge CLK_IN)
    begin
        ext_vld <= 1'b0;
        if (ext_wr)
        begin
            ext_wr_cnt++;
            ext_wr_adr_log.push_back(ext_adr);
            ext_wr_dat_log.push_back(ext_din);
        end
        if (ext_rd)
        begin
            ext_rd_cnt++;
            rd_pending = 1'b1;
            rd_wait    = 1 + ($unsigned($random(seed)) % 8);
            rd_adr     = ext_adr;
        end
        else if (rd_pending)
        begin
            rd_wait--;
            if (rd_wait == 0)
            begin
                ext_vld    <= 1'b1;
                ext_dout   <= {16'd0, rd_adr} ^ EXT_KEY;
                rd_pending = 1'b0;
            end
        end
    end

    // Host address of a local-bus target register
    function automatic host_adr_t lb_host_adr(input int port, input int rnum);
        host_adr_t a;
        a = 32'h8000_0000;
        a[23:18] = port[5:0];
        a[17:2]  = rnum[15:0];
        return a;
    endfunction

    // RAM ignores bits above 11
    // External index in bits 23:18 exposes a leak onto the local bus
    function automatic host_adr_t ram_host_adr(input ram_adr_t idx);
        host_adr_t a;
        a = '0;
        a[23:18] = LB_PORT_EXT;
        a[11:2]  = idx;
        return a;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One-cycle write strobe
    task automatic host_write(input host_adr_t adr, input word_t dat, input strb_t strb);
        @(posedge CLK_IN);
        host_adr     <= adr;
        host_wr      <= 1'b1;
        host_wr_dat  <= dat;
        host_wr_strb <= strb;
        @(posedge CLK_IN);
        host_wr <= 1'b0;
    endtask

    // Read strobe then wait for valid
    // Latency counted in cycles after the strobe
    task automatic host_read(input host_adr_t adr, output word_t dat, output int lat);
        @(posedge CLK_IN);
        host_adr <= adr;
        host_rd  <= 1'b1;
        @(posedge CLK_IN);
        host_rd <= 1'b0;
        lat = 1;
        @(negedge CLK_IN);
        while (!host_rd_vld && lat < 50)
        begin
            @(negedge CLK_IN);
            lat++;
        end
        if (!host_rd_vld)
        begin
            errors++;
            $display("Read at %h never returned a valid", adr);
        end
        dat = host_rd_dat;
    endtask

    task automatic test_reset_state();
        word_t d;
        int    lat;
        @(negedge CLK_IN);
        check_bit("reset host_rd_vld", 1'b0, host_rd_vld);
        check_bit("reset ext_wr", 1'b0, ext_wr);
        check_bit("reset ext_rd", 1'b0, ext_rd);
        check_bit("reset irq", 1'b0, irq);
        check_word("reset pio_out", 32'd0, pio_out);
        host_read(lb_host_adr(LB_PORT_TMR, TMR_REG_CNT), d, lat);
        check_word("reset timer count", 32'd0, d);
        host_read(lb_host_adr(LB_PORT_TMR, TMR_REG_CTL), d, lat);
        check_word("reset timer stopped", 32'd0, d);
    endtask

    // Full words first so partial strobes never touch unknown lanes
    task automatic test_ram();
        word_t    model [1024];
        ram_adr_t idx [16];
        word_t    d;
        strb_t    s;
        int       lat;
        int       strobes;
        strobes = ext_wr_cnt + ext_rd_cnt;
        for (int i = 0; i < 16; i++)
        begin
            idx[i] = ram_adr_t'($random(seed));
            d = $random(seed);
            host_write(ram_host_adr(idx[i]), d, 4'hF);
            model[idx[i]] = d;
        end
        for (int i = 0; i < 16; i++)
        begin
            d = $random(seed);
            s = strb_t'($random(seed));
            host_write(ram_host_adr(idx[i]), d, s);
            for (int b = 0; b < 4; b++)
            begin
                if (s[b])
                    model[idx[i]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
        for (int i = 0; i < 16; i++)
        begin
            host_read(ram_host_adr(idx[i]), d, lat);
            check_word("ram data", model[idx[i]], d);
            check_word("ram latency", 32'd1, word_t'(lat));
        end
        check_word("ext strobes during ram", word_t'(strobes),
                   word_t'(ext_wr_cnt + ext_rd_cnt));
    endtask

    task automatic test_pio();
        word_t exp_out;
        word_t d;
        int    lat;
        int    strobes;
        strobes = ext_wr_cnt + ext_rd_cnt;
        // Major 1 upper half, minor 2 lower half
        host_read(lb_host_adr(LB_PORT_PIO, PIO_REG_VER), d, lat);
        check_word("pio version", 32'h0001_0002, d);
        check_word("pio latency", 32'd1, word_t'(lat));
        exp_out = 32'h1234_5678;
        host_write(lb_host_adr(LB_PORT_PIO, PIO_REG_OUT), exp_out, 4'hF);
        @(negedge CLK_IN);
        check_word("pio out write", exp_out, pio_out);
        host_write(lb_host_adr(LB_PORT_PIO, PIO_REG_SET), 32'h0000_FF00, 4'hF);
        exp_out = exp_out | 32'h0000_FF00;
        @(negedge CLK_IN);
        check_word("pio set", exp_out, pio_out);
        host_write(lb_host_adr(LB_PORT_PIO, PIO_REG_CLR), 32'h1030_0070, 4'hF);
        exp_out = exp_out & ~32'h1030_0070;
        @(negedge CLK_IN);
        check_word("pio clear", exp_out, pio_out);
        host_read(lb_host_adr(LB_PORT_PIO, PIO_REG_OUT), d, lat);
        check_word("pio out readback", exp_out, d);
        @(posedge CLK_IN);
        pio_in <= 32'hCAFE_0123;
        host_read(lb_host_adr(LB_PORT_PIO, PIO_REG_IN), d, lat);
        check_word("pio in", 32'hCAFE_0123, d);
        host_read(lb_host_adr(LB_PORT_PIO, 9), d, lat);
        check_word("pio unknown reg", 32'd0, d);
        check_word("ext strobes during pio", word_t'(strobes),
                   word_t'(ext_wr_cnt + ext_rd_cnt));
    endtask

    task automatic test_ext_port();
        word_t    d;
        int       lat;
        int       n;
        reg_adr_t a;
        n = ext_wr_cnt;
        host_write(lb_host_adr(LB_PORT_EXT, 16'h1234), 32'hA5A5_0F0F, 4'hF);
        @(negedge CLK_IN);
        check_word("ext write count", word_t'(n + 1), word_t'(ext_wr_cnt));
        check_word("ext write adr", 32'h0000_1234, word_t'(ext_wr_adr_log[$]));
        check_word("ext write data", 32'hA5A5_0F0F, ext_wr_dat_log[$]);
        for (int i = 0; i < 6; i++)
        begin
            a = reg_adr_t'($random(seed));
            host_read(lb_host_adr(LB_PORT_EXT, a), d, lat);
            check_word("ext read data", {16'd0, a} ^ EXT_KEY, d);
        end
    endtask

    task automatic test_unmapped();
        word_t d;
        int    lat;
        host_read(lb_host_adr(5, 3), d, lat);
        check_word("unmapped data", 32'd0, d);
        check_word("unmapped latency", 32'd1, word_t'(lat));
    endtask

    task automatic test_timer();
        word_t d;
        int    lat;
        int    n;
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_CTL), 32'd1, 4'hF);
        // Ten microseconds at 50 clocks each
        repeat (10 * 50) @(posedge CLK_IN);
        host_read(lb_host_adr(LB_PORT_TMR, TMR_REG_CNT), d, lat);
        if (d < 9 || d > 11)
        begin
            errors++;
            $display("FAIL timer count: expected 9..11, actual %0d", d);
        end
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_CTL), 32'd0, 4'hF);
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_CMP), 32'd5, 4'hF);
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_STA), 32'd1, 4'hF);
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_CTL), 32'd1, 4'hF);
        n = 0;
        @(negedge CLK_IN);
        while (!irq && n < 6 * 50 + 20)
        begin
            @(negedge CLK_IN);
            n++;
        end
        check_bit("timer compare irq", 1'b1, irq);
        host_read(lb_host_adr(LB_PORT_TMR, TMR_REG_STA), d, lat);
        check_word("timer status", 32'd1, d);
        // Write one to clear
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_STA), 32'd1, 4'hF);
        @(negedge CLK_IN);
        check_bit("timer irq cleared", 1'b0, irq);
        host_write(lb_host_adr(LB_PORT_TMR, TMR_REG_CTL), 32'd0, 4'hF);
    endtask

    task automatic test_irq_merge();
        @(posedge CLK_IN);
        ext_irq <= 1'b1;
        @(negedge CLK_IN);
        check_bit("irq follows ext_irq high", 1'b1, irq);
        @(posedge CLK_IN);
        ext_irq <= 1'b0;
        @(negedge CLK_IN);
        check_bit("irq follows ext_irq low", 1'b0, irq);
    endtask

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        errors       = 0;
        seed         = 59339;
        ext_wr_cnt   = 0;
        ext_rd_cnt   = 0;
        rd_pending   = 1'b0;
        rd_wait      = 0;
        rd_adr       = '0;
        reset        = 1'b1;
        host_adr     = '0;
        host_wr      = 1'b0;
        host_rd      = 1'b0;
        host_wr_dat  = '0;
        host_wr_strb = '0;
        pio_in       = '0;
        ext_dout     = '0;
        ext_vld      = 1'b0;
        ext_irq      = 1'b0;
        repeat (10) @(posedge CLK_IN);
        reset <= 1'b0;
        // Registered reset lags by one cycle
        repeat (2) @(posedge CLK_IN);
        test_reset_state();
        test_ram();
        test_pio();
        test_ext_port();
        test_unmapped();
        test_timer();
        test_irq_merge();
        repeat (2) @(posedge CLK_IN);
        $display("Tests done, %0d errors", errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
source/app_pkg.sv
source/app_data_ram.sv
source/app_lb_mux.sv
source/app_pio.sv
source/app_timer.sv
source/app_top.sv
test/tb_app_top.sv

// ==== Bender.yml ====
package:
  name: app_core

sources:
  - source/app_pkg.sv
  - source/app_data_ram.sv
  - source/app_lb_mux.sv
  - source/app_pio.sv
  - source/app_timer.sv
  - source/app_top.sv
  - target: test
    files:
      - test/tb_app_top.sv
